/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/id_pkg.sv
      - common/dec_ctrl_if.sv
      - decode/inst_decoder.sv
      - hdl/operand_mux.sv
      - hdl/branch_resolver.sv
      - hdl/hazard_unit.sv
      - hdl/id_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_id_stage.sv

/* common/dec_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dec_ctrl_if import id_pkg::*; ();

    alu_op_e   aluop;
    alu_sel_e  alusel;
    logic      reg_we;
    logic      rs1_re;
    logic      rs2_re;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    op1_sel_e  op1_sel;
    br_kind_e  br_kind;
    logic      is_load;

    modport decoder (output aluop, alusel, reg_we, rs1_re, rs2_re, rs1, rs2, rd,
                     imm, op1_sel, br_kind, is_load);
    modport operand (input rs1, rs2, rs2_re, imm, op1_sel);
    modport branch  (input br_kind, imm);
    modport hazard  (input is_load, rd, rs1, rs2, rs1_re, rs2_re);

endinterface

`default_nettype wire

/* common/id_pkg.sv */
`default_nettype none
`include "id_settings.svh"

package id_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]            inst_t;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_OR, ALU_XOR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,   // m extension in funct3 order
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU, ALU_SB, ALU_SH, ALU_SW,
        ALU_JAL, ALU_JALR
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MUL, SEL_DIV, SEL_LOAD_STORE, SEL_JUMP
    } alu_sel_e;

    typedef enum logic [1:0] {OP1_REG, OP1_IMM, OP1_PC, OP1_PC_PLUS4} op1_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_kind_e;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD = 3'd0, F3_SLL = 3'd1, F3_SLT = 3'd2, F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR = 3'd4, F3_SR  = 3'd5, F3_OR  = 3'd6, F3_AND  = 3'd7;
    localparam logic [2:0] F3_LB  = 3'd0, F3_LH  = 3'd1, F3_LW  = 3'd2;
    localparam logic [2:0] F3_LBU = 3'd4, F3_LHU = 3'd5;
    localparam logic [2:0] F3_SB  = 3'd0, F3_SH  = 3'd1, F3_SW  = 3'd2;
    localparam logic [2:0] F3_BEQ = 3'd0, F3_BNE = 3'd1, F3_BLT = 3'd4, F3_BGE = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6, F3_BGEU = 3'd7;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra, srai
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

/* common/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// canonical nop is addi x0, x0, 0
`define NOP_INST    32'h0000_0013

`endif

/* decode/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module inst_decoder import id_pkg::*; (
    input  inst_t        inst_i,
    input  logic         flush_i,
    dec_ctrl_if.decoder  ctrl
);

    inst_t      word;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e    op;
    br_kind_e   br;
    logic       legal;

    function automatic alu_op_e arith_op(logic [2:0] f3, logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_sel_e sel_of(alu_op_e op_in);
        case (op_in) inside
            ALU_OR, ALU_XOR, ALU_AND:         return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:        return SEL_SHIFT;
            [ALU_ADD:ALU_SLTU]:               return SEL_ARITH;
            [ALU_MUL:ALU_MULHU]:              return SEL_MUL;
            [ALU_DIV:ALU_REMU]:               return SEL_DIV;
            [ALU_LB:ALU_SW]:                  return SEL_LOAD_STORE;
            ALU_JAL, ALU_JALR:                return SEL_JUMP;
            default:                          return SEL_NOP;
        endcase
    endfunction

    assign word   = flush_i ? `NOP_INST : inst_i;
    assign opcode = word[6:0];
    assign funct3 = word[14:12];
    assign funct7 = word[31:25];

    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // operation and branch kind

    always_comb begin
        op = ALU_NOP;
        br = BR_NONE;
        case (opcode)
            OPC_LUI:   op = ALU_OR;      // imm or imm
            OPC_AUIPC: op = ALU_ADD;
            OPC_JAL: begin
                op = ALU_JAL;
                br = BR_JAL;
            end
            OPC_JALR: begin
                op = ALU_JALR;
                br = BR_JALR;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  br = BR_BEQ;
                    F3_BNE:  br = BR_BNE;
                    F3_BLT:  br = BR_BLT;
                    F3_BGE:  br = BR_BGE;
                    F3_BLTU: br = BR_BLTU;
                    F3_BGEU: br = BR_BGEU;
                    default: br = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   op = ALU_LB;
                    F3_LH:   op = ALU_LH;
                    F3_LW:   op = ALU_LW;
                    F3_LBU:  op = ALU_LBU;
                    F3_LHU:  op = ALU_LHU;
                    default: op = ALU_NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   op = ALU_SB;
                    F3_SH:   op = ALU_SH;
                    F3_SW:   op = ALU_SW;
                    default: op = ALU_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                // only the shifts carry a funct7
                if (!(funct3 inside {F3_SLL, F3_SR}) || funct7 == F7_BASE ||
                    (funct7 == F7_ALT && funct3 == F3_SR)) begin
                    op = arith_op(funct3, funct7 == F7_ALT && funct3 == F3_SR);
                end
            end
            OPC_OP: begin
                if (funct7 == F7_MULDIV) begin
                    op = alu_op_e'(ALU_MUL + funct3);
                end else if (funct7 == F7_BASE ||
                             (funct7 == F7_ALT && funct3 inside {F3_ADD, F3_SR})) begin
                    op = arith_op(funct3, funct7 == F7_ALT);
                end
            end
            default: ;
        endcase
    end

    // immediate format and operand 1 source
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: ctrl.imm = imm_u;
            OPC_JAL:            ctrl.imm = imm_j;
            OPC_BRANCH:         ctrl.imm = imm_b;
            OPC_STORE:          ctrl.imm = imm_s;
            OPC_OP:             ctrl.imm = '0;
            default:            ctrl.imm = imm_i;
        endcase
        if (!legal) begin
            ctrl.imm = '0;
        end
        case (opcode)
            OPC_LUI:            ctrl.op1_sel = OP1_IMM;
            OPC_AUIPC:          ctrl.op1_sel = OP1_PC;
            OPC_JAL, OPC_JALR:  ctrl.op1_sel = OP1_PC_PLUS4;   // link value
            default:            ctrl.op1_sel = OP1_REG;
        endcase
    end

    assign legal = (op != ALU_NOP || br != BR_NONE) && word != `NOP_INST;

    assign ctrl.aluop   = legal ? op : ALU_NOP;
    assign ctrl.alusel  = sel_of(ctrl.aluop);
    assign ctrl.br_kind = legal ? br : BR_NONE;
    assign ctrl.is_load = legal && opcode == OPC_LOAD;
    assign ctrl.reg_we  = legal && opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                                  OPC_LOAD, OPC_OP_IMM, OPC_OP};
    assign ctrl.rs1_re  = legal && opcode inside {OPC_JALR, OPC_BRANCH, OPC_LOAD,
                                                  OPC_STORE, OPC_OP_IMM, OPC_OP};
    assign ctrl.rs2_re  = legal && opcode inside {OPC_BRANCH, OPC_STORE, OPC_OP};
    assign ctrl.rs1     = word[19:15];
    assign ctrl.rs2     = word[24:20];
    assign ctrl.rd      = word[11:7];

    a_store_no_we: assert final (!(ctrl.reg_we && ctrl.aluop inside {ALU_SB, ALU_SH, ALU_SW}));

endmodule

`default_nettype wire

/* hdl/branch_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolver import id_pkg::*; (
    dec_ctrl_if.branch  ctrl,
    input  word_t       pc_i,
    input  word_t       src1_i,
    input  word_t       src2_i,
    input  logic        prediction_i,
    input  word_t       prediction_pc_i,
    output logic        branch_flag_o,
    output word_t       branch_address_o,
    output logic        prediction_ok_o,
    output logic        is_branch_o
);

    logic eq, lt, ltu;
    logic taken;

    assign eq  = src1_i == src2_i;
    assign lt  = $signed(src1_i) < $signed(src2_i);
    assign ltu = src1_i < src2_i;

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:           taken = eq;
            BR_BNE:           taken = !eq;
            BR_BLT:           taken = lt;
            BR_BGE:           taken = !lt;
            BR_BLTU:          taken = ltu;
            BR_BGEU:          taken = !ltu;
            BR_JAL, BR_JALR:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    assign branch_address_o = (ctrl.br_kind == BR_JALR) ? ((src1_i + ctrl.imm) & ~word_t'(1))
                                                        : pc_i + ctrl.imm;

    assign is_branch_o   = ctrl.br_kind != BR_NONE;
    assign branch_flag_o = taken;

    always_comb begin
        if (!is_branch_o) begin
            prediction_ok_o = 1'b1;
        end else if (taken) begin
            prediction_ok_o = prediction_i && (prediction_pc_i == branch_address_o);
        end else begin
            prediction_ok_o = !prediction_i;   // fall-through was predicted
        end
    end

    a_flag_is_branch: assert final (!branch_flag_o || is_branch_o);

endmodule

`default_nettype wire

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import id_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    dec_ctrl_if.hazard  ctrl,
    output logic        stall_o
);

    logic      last_load;     // last issued instruction was a load
    reg_addr_t last_rd;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_load <= 1'b0;
        end else begin
            last_load <= ctrl.is_load && !stall_o;   // stalled slot issues nothing
        end
    end

    always_ff @(posedge clk) begin
        last_rd <= ctrl.rd;
    end

    assign stall_o = last_load && (last_rd != '0) &&
                     ((ctrl.rs1_re && ctrl.rs1 == last_rd) ||
                      (ctrl.rs2_re && ctrl.rs2 == last_rd));

    // one bubble is enough for the load data to reach the mem forward path
    a_single_bubble: assert property (@(posedge clk) disable iff (reset_i)
                                      stall_o |=> !stall_o);

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,

    // from fetch
    input  word_t      pc_i,
    input  inst_t      inst_i,
    input  logic       flush_i,
    input  logic       prediction_i,
    input  word_t      prediction_pc_i,

    // register file
    input  word_t      reg1_data_i,
    input  word_t      reg2_data_i,
    output reg_addr_t  reg1_addr_o,
    output reg_addr_t  reg2_addr_o,
    output logic       reg1_re_o,
    output logic       reg2_re_o,

    // forwarding
    input  logic       ex_we_i,
    input  reg_addr_t  ex_waddr_i,
    input  word_t      ex_wdata_i,
    input  logic       mem_we_i,
    input  reg_addr_t  mem_waddr_i,
    input  word_t      mem_wdata_i,

    // to execute
    output alu_op_e    aluop_o,
    output alu_sel_e   alusel_o,
    output word_t      op1_o,
    output word_t      op2_o,
    output reg_addr_t  reg_waddr_o,
    output logic       reg_we_o,

    // to fetch and pipeline control
    output logic       branch_flag_o,
    output word_t      branch_address_o,
    output logic       prediction_ok_o,
    output logic       is_branch_o,
    output logic       stall_o
);

    dec_ctrl_if ctrl ();

    word_t src1, src2;   // forwarded source values

    inst_decoder u_decoder (
        .inst_i  (inst_i),
        .flush_i (flush_i),
        .ctrl    (ctrl.decoder)
    );

    operand_mux u_operand (
        .ctrl        (ctrl.operand),
        .pc_i        (pc_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_we_i     (ex_we_i),
        .ex_waddr_i  (ex_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .op1_o       (op1_o),
        .op2_o       (op2_o),
        .src1_o      (src1),
        .src2_o      (src2)
    );

    branch_resolver u_branch (
        .ctrl             (ctrl.branch),
        .pc_i             (pc_i),
        .src1_i           (src1),
        .src2_i           (src2),
        .prediction_i     (prediction_i),
        .prediction_pc_i  (prediction_pc_i),
        .branch_flag_o    (branch_flag_o),
        .branch_address_o (branch_address_o),
        .prediction_ok_o  (prediction_ok_o),
        .is_branch_o      (is_branch_o)
    );

    hazard_unit u_hazard (
        .clk     (clk),
        .reset_i (reset_i),
        .ctrl    (ctrl.hazard),
        .stall_o (stall_o)
    );

    assign reg1_addr_o = ctrl.rs1;
    assign reg2_addr_o = ctrl.rs2;
    assign reg1_re_o   = ctrl.rs1_re;
    assign reg2_re_o   = ctrl.rs2_re;
    assign aluop_o     = ctrl.aluop;
    assign alusel_o    = ctrl.alusel;
    assign reg_waddr_o = ctrl.rd;
    assign reg_we_o    = ctrl.reg_we;

endmodule

`default_nettype wire

/* hdl/operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_mux import id_pkg::*; (
    dec_ctrl_if.operand  ctrl,
    input  word_t        pc_i,
    input  word_t        reg1_data_i,
    input  word_t        reg2_data_i,
    input  logic         ex_we_i,
    input  reg_addr_t    ex_waddr_i,
    input  word_t        ex_wdata_i,
    input  logic         mem_we_i,
    input  reg_addr_t    mem_waddr_i,
    input  word_t        mem_wdata_i,
    output word_t        op1_o,
    output word_t        op2_o,
    output word_t        src1_o,
    output word_t        src2_o
);

    logic ex1_hit, mem1_hit, ex2_hit, mem2_hit;

    // x0 is never forwarded
    function automatic logic fwd_hit(logic we, reg_addr_t waddr, reg_addr_t rs);
        return we && (waddr == rs) && (rs != '0);
    endfunction

    assign ex1_hit  = fwd_hit(ex_we_i, ex_waddr_i, ctrl.rs1);
    assign mem1_hit = fwd_hit(mem_we_i, mem_waddr_i, ctrl.rs1);
    assign ex2_hit  = fwd_hit(ex_we_i, ex_waddr_i, ctrl.rs2);
    assign mem2_hit = fwd_hit(mem_we_i, mem_waddr_i, ctrl.rs2);

    // execute is younger than memory, so it wins
    assign src1_o = ex1_hit ? ex_wdata_i : (mem1_hit ? mem_wdata_i : reg1_data_i);
    assign src2_o = ex2_hit ? ex_wdata_i : (mem2_hit ? mem_wdata_i : reg2_data_i);

    always_comb begin
        case (ctrl.op1_sel)
            OP1_IMM:      op1_o = ctrl.imm;
            OP1_PC:       op1_o = pc_i;
            OP1_PC_PLUS4: op1_o = pc_i + 32'd4;
            default:      op1_o = src1_o;
        endcase
    end

    assign op2_o = ctrl.rs2_re ? src2_o : ctrl.imm;

    a_fwd_nonzero: assert final (!((ex1_hit || ex2_hit) && ex_waddr_i == '0) &&
                                 !((mem1_hit || mem2_hit) && mem_waddr_i == '0));

endmodule

`default_nettype wire

/* sim/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int TEST_CYCLES = 100;   // reset plus all directed tests
    localparam int MARGIN      = 50;

    logic      clk = 1'b0;
    logic      reset_i, flush_i, prediction_i;
    word_t     pc_i, prediction_pc_i, reg1_data_i, reg2_data_i;
    inst_t     inst_i;
    reg_addr_t reg1_addr_o, reg2_addr_o, reg_waddr_o, ex_waddr_i, mem_waddr_i;
    logic      reg1_re_o, reg2_re_o, reg_we_o, ex_we_i, mem_we_i;
    word_t     ex_wdata_i, mem_wdata_i, op1_o, op2_o, branch_address_o;
    alu_op_e   aluop_o;
    alu_sel_e  alusel_o;
    logic      branch_flag_o, prediction_ok_o, is_branch_o, stall_o;

    logic [15:0] lfsr = 16'd60655;
    word_t       r1, r2, pcv;   // operands for the next instruction

    id_stage dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    // fibonacci taps x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic expect_eq(string sig, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", sig, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic drive_edge();
        @(posedge clk);
        #5;
    endtask

    task automatic new_operands();
        r1  = rand_bits(32);
        r2  = rand_bits(32);
        pcv = rand_bits(32) & 32'hffff_fffc;
    endtask

    // present one instruction and let the outputs settle
    task automatic apply(inst_t inst);
        drive_edge();
        inst_i      = inst;
        pc_i        = pcv;
        reg1_data_i = r1;
        reg2_data_i = r2;
        #20;
    endtask

    task automatic check_alu(inst_t inst, alu_op_e op, alu_sel_e sel, logic we,
                             logic re1, logic re2, reg_addr_t a1, reg_addr_t a2,
                             reg_addr_t wa, word_t exp1, word_t exp2);
        apply(inst);
        expect_eq("aluop_o", word_t'(aluop_o), word_t'(op));
        expect_eq("alusel_o", word_t'(alusel_o), word_t'(sel));
        expect_eq("reg_we_o", reg_we_o, we);
        expect_eq("reg1_re_o", reg1_re_o, re1);
        expect_eq("reg2_re_o", reg2_re_o, re2);
        if (re1) begin
            expect_eq("reg1_addr_o", reg1_addr_o, a1);
        end
        if (re2) begin
            expect_eq("reg2_addr_o", reg2_addr_o, a2);
        end
        if (we) begin
            expect_eq("reg_waddr_o", reg_waddr_o, wa);
        end
        expect_eq("op1_o", op1_o, exp1);
        expect_eq("op2_o", op2_o, exp2);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset_state();
        apply(`NOP_INST);
        expect_eq("stall_o", stall_o, 0);
        expect_eq("branch_flag_o", branch_flag_o, 0);
        expect_eq("is_branch_o", is_branch_o, 0);
        expect_eq("reg_we_o", reg_we_o, 0);
        expect_eq("reg1_re_o", reg1_re_o, 0);
        expect_eq("reg2_re_o", reg2_re_o, 0);
        expect_eq("prediction_ok_o", prediction_ok_o, 1);
    endtask

    task automatic test_alu_decode();
        new_operands();
        check_alu(enc_i(12'hffb, 1, F3_ADD, 3, OPC_OP_IMM), ALU_ADD, SEL_ARITH, 1, 1, 0,
                  1, 0, 3, r1, 32'hffff_fffb);
        check_alu({20'h12345, 5'd4, OPC_LUI}, ALU_OR, SEL_LOGIC, 1, 0, 0,
                  0, 0, 4, 32'h1234_5000, 32'h1234_5000);
        check_alu({20'habcde, 5'd4, OPC_AUIPC}, ALU_ADD, SEL_ARITH, 1, 0, 0,
                  0, 0, 4, pcv, 32'habcd_e000);
        new_operands();
        check_alu(enc_r(F7_ALT, 2, 1, F3_ADD, 5), ALU_SUB, SEL_ARITH, 1, 1, 1,
                  1, 2, 5, r1, r2);
        check_alu(enc_r(F7_ALT, 2, 1, F3_SR, 5), ALU_SRA, SEL_SHIFT, 1, 1, 1,
                  1, 2, 5, r1, r2);
        check_alu(enc_r(F7_MULDIV, 2, 1, 3'd0, 5), ALU_MUL, SEL_MUL, 1, 1, 1,
                  1, 2, 5, r1, r2);
        check_alu(enc_r(F7_MULDIV, 2, 1, 3'd5, 5), ALU_DIVU, SEL_DIV, 1, 1, 1,
                  1, 2, 5, r1, r2);
        check_alu({7'd0, 5'd2, 5'd1, F3_SW, 5'd8, OPC_STORE}, ALU_SW, SEL_LOAD_STORE,
                  0, 1, 1, 1, 2, 0, r1, r2);
    endtask

    task automatic test_forwarding();
        word_t exv, memv;
        new_operands();
        exv  = rand_bits(32);
        memv = rand_bits(32);
        apply(enc_r(F7_BASE, 2, 1, F3_ADD, 6));
        drive_edge();
        {ex_we_i, ex_waddr_i, ex_wdata_i}    = {1'b1, 5'd1, exv};
        {mem_we_i, mem_waddr_i, mem_wdata_i} = {1'b1, 5'd1, memv};
        #20;
        expect_eq("op1_o", op1_o, exv);      // execute wins
        drive_edge();
        ex_we_i = 1'b0;
        #20;
        expect_eq("op1_o", op1_o, memv);
        drive_edge();
        {ex_we_i, ex_waddr_i, mem_waddr_i} = {1'b1, 5'd7, 5'd9};
        #20;
        expect_eq("op1_o", op1_o, r1);
        apply(enc_r(F7_BASE, 2, 0, F3_ADD, 6));
        drive_edge();
        {ex_waddr_i, mem_waddr_i} = {5'd0, 5'd0};
        #20;
        expect_eq("op1_o", op1_o, r1);       // x0 never forwarded
        drive_edge();
        {ex_we_i, mem_we_i} = 2'b00;
    endtask

    task automatic test_load_use();
        apply(enc_i(12'd0, 1, F3_LW, 5, OPC_LOAD));
        expect_eq("stall_o", stall_o, 0);
        apply(enc_r(F7_BASE, 2, 5, F3_ADD, 6));
        expect_eq("stall_o", stall_o, 1);
        apply(enc_r(F7_BASE, 2, 5, F3_ADD, 6));
        expect_eq("stall_o", stall_o, 0);    // bubble already taken
        apply(enc_i(12'd1, 0, F3_ADD, 7, OPC_OP_IMM));
        apply(enc_r(F7_BASE, 7, 7, F3_ADD, 8));
        expect_eq("stall_o", stall_o, 0);
    endtask

    task automatic test_branches();
        logic [2:0]  kinds [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        logic [31:0] tmp;
        word_t       off, target;
        logic        taken;
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < 2; s++) begin
                new_operands();
                if (s == 1) r2 = r1;        // equal operands
                tmp    = rand_bits(12);
                off    = {{19{tmp[11]}}, tmp[11:0], 1'b0};
                target = pcv + off;
                taken  = branch_taken(kinds[k], r1, r2);
                apply(enc_b(off[12:0], 2, 1, kinds[k]));
                expect_eq("is_branch_o", is_branch_o, 1);
                for (int p = 0; p < 4; p++) begin
                    drive_edge();
                    prediction_i    = p[1];
                    prediction_pc_i = p[0] ? target + 32'd4 : target;
                    #20;
                    expect_eq("branch_flag_o", branch_flag_o, taken);
                    expect_eq("branch_address_o", branch_address_o, target);
                    expect_eq("prediction_ok_o", prediction_ok_o,
                              taken ? (p[1] && !p[0]) : !p[1]);
                end
            end
        end
        new_operands();
        tmp = rand_bits(20);
        off = {{11{tmp[19]}}, tmp[19:0], 1'b0};
        apply({off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL});
        expect_eq("is_branch_o", is_branch_o, 1);
        expect_eq("branch_flag_o", branch_flag_o, 1);
        expect_eq("branch_address_o", branch_address_o, pcv + off);
        expect_eq("op1_o", op1_o, pcv + 32'd4);
        tmp = rand_bits(12);
        off = {{20{tmp[11]}}, tmp[11:0]};
        apply(enc_i(tmp[11:0], 3, 3'd0, 1, OPC_JALR));
        expect_eq("is_branch_o", is_branch_o, 1);
        expect_eq("branch_flag_o", branch_flag_o, 1);
        expect_eq("branch_address_o", branch_address_o, (r1 + off) & 32'hffff_fffe);
        expect_eq("op1_o", op1_o, pcv + 32'd4);
    endtask

    task automatic test_flush();
        drive_edge();
        flush_i = 1'b1;
        inst_i  = enc_i(12'd0, 1, F3_LW, 5, OPC_LOAD);
        #20;
        expect_eq("reg_we_o", reg_we_o, 0);
        expect_eq("reg1_re_o", reg1_re_o, 0);
        expect_eq("reg2_re_o", reg2_re_o, 0);
        expect_eq("branch_flag_o", branch_flag_o, 0);
        expect_eq("is_branch_o", is_branch_o, 0);
        drive_edge();
        flush_i = 1'b0;
        inst_i  = enc_r(F7_BASE, 2, 5, F3_ADD, 6);
        #20;
        expect_eq("stall_o", stall_o, 0);    // flushed load left no hazard
    endtask

    ////////////////////////////////////////////////////////////////////////////

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        reset_i         = 1'b1;
        flush_i         = 1'b0;
        prediction_i    = 1'b0;
        prediction_pc_i = '0;
        pc_i            = '0;
        inst_i          = `NOP_INST;
        reg1_data_i     = '0;
        reg2_data_i     = '0;
        {ex_we_i, ex_waddr_i, ex_wdata_i}    = '0;
        {mem_we_i, mem_waddr_i, mem_wdata_i} = '0;
        {r1, r2, pcv}   = '0;
        repeat (8) @(posedge clk);
        #5;
        reset_i = 1'b0;

        test_reset_state();
        test_alu_decode();
        test_forwarding();
        test_load_use();
        test_branches();
        test_flush();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/id_pkg.sv
common/dec_ctrl_if.sv
decode/inst_decoder.sv
hdl/operand_mux.sv
hdl/branch_resolver.sv
hdl/hazard_unit.sv
hdl/id_stage.sv
sim/tb_id_stage.sv
